// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_mult_saxi_wr
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/chn_buf_pkg.sv ====
// channel buffer types
// sample, 32-bit buffer word seen as word or as sample lanes, burst count
// plus the address widths of one channel buffer
`include "saxi_wr_config.svh"

package chn_buf_pkg;

    localparam int SMP_W    = 1 << `SAXI_WLOG;                     // bits per sample
    localparam int LANE_LOG = 5 - `SAXI_WLOG;                      // samples per word, log2
    localparam int LANES    = 1 << LANE_LOG;
    localparam int WORD_AW  = `SAXI_BUF_BURSTS_LOG + `SAXI_BSLOG;  // word address bits
    localparam int SMP_AW   = WORD_AW + LANE_LOG;                  // sample address bits
    localparam int DEPTH    = 1 << WORD_AW;                        // words per buffer

    typedef logic [SMP_W-1:0] sample_t;

    // written per lane, read as one word
    typedef union packed {
        logic [31:0]         word;
        sample_t [LANES-1:0] lane;  // lane 0 in the low half
    } buf_word_t;

    typedef logic [`SAXI_BUF_BURSTS_LOG:0] burst_cnt_t;  // one extra bit for full

endpackage

// ==== hdl/chn_buf_ram.sv ====
// behavioral dual-clock buffer RAM
// sample-wide write port, 32-bit read port with latch and output register
`timescale 1ns/1ns

module chn_buf_ram (
    input  logic                            wclk,
    input  logic [chn_buf_pkg::SMP_AW-1:0]  waddr,
    input  logic                            we,
    input  chn_buf_pkg::sample_t            wdata,
    input  logic                            rclk,
    input  logic [chn_buf_pkg::WORD_AW-1:0] raddr,
    input  logic                            ren,
    input  logic                            regen,
    output chn_buf_pkg::buf_word_t          rdata
);
    import chn_buf_pkg::*;

    buf_word_t mem [DEPTH];  // word array, lanes written one by one
    buf_word_t rd_lat;       // array read stage

    // upper address bits pick the word, low bits the lane
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr[SMP_AW-1:LANE_LOG]].lane[waddr[LANE_LOG-1:0]] <= wdata;
        end
    end

    always_ff @(posedge rclk) begin
        if (ren) begin
            rd_lat.word <= mem[raddr].word;  // whole word at once
        end
        if (regen) begin
            rdata <= rd_lat;  // output register stage
        end
    end

endmodule

// ==== hdl/chn_rd_if.sv ====
// burst read link between one channel buffer and the arbiter
// buffer side reports bursts and data, arbiter side requests a burst
`timescale 1ns/1ns

interface chn_rd_if;
    import chn_buf_pkg::*;

    logic      has_burst;   // at least one full burst held
    logic      read_burst;  // one-cycle request from arbiter
    logic      pre_valid;   // data valid one cycle later
    buf_word_t data;        // registered RAM output

    modport buf_mp (
        output has_burst, pre_valid, data,
        input  read_burst
    );

    modport arb_mp (
        input  has_burst, pre_valid, data,
        output read_burst
    );
endinterface

// ==== hdl/mult_saxi_wr.sv ====
// multi-channel write collector, top level
// channel buffers and round-robin arbiter joined by read links
`timescale 1ns/1ns
`include "saxi_wr_config.svh"

module mult_saxi_wr (
    input  logic                                    iclk,
    input  logic                                    arst_n,
    input  logic                                    data_clk,
    input  logic [`SAXI_NCHN-1:0]                   en,
    input  logic [`SAXI_NCHN*(1<<`SAXI_WLOG)-1:0]   data_in,   // channel 0 in low bits
    input  logic [`SAXI_NCHN-1:0]                   valid,
    output logic                                    wr_start,
    output saxi_wr_pkg::wr_addr_t                   wr_addr,
    output logic [31:0]                             wr_data,
    output logic                                    wr_valid,
    output logic                                    wr_last
);

    localparam int SMP_W = 1 << `SAXI_WLOG;

    chn_rd_if rd_if [`SAXI_NCHN] ();  // one read link per channel

    for (genvar i = 0; i < `SAXI_NCHN; i++) begin : g_chn
        mult_saxi_wr_inbuf i_inbuf (
            .iclk     (iclk),
            .arst_n   (arst_n),
            .en       (en[i]),
            .data_clk (data_clk),
            .data_in  (data_in[i*SMP_W +: SMP_W]),
            .valid    (valid[i]),
            .rd       (rd_if[i])
        );
    end

    mult_saxi_wr_arb i_arb (
        .iclk     (iclk),
        .arst_n   (arst_n),
        .chn      (rd_if),
        .wr_start (wr_start),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_valid (wr_valid),
        .wr_last  (wr_last)
    );

endmodule

// ==== hdl/mult_saxi_wr_arb.sv ====
// round-robin burst arbiter
// picks a channel with a full burst, issues read_burst and wr_start,
// keeps per-channel burst indices, muxes the served channel onto the stream
`timescale 1ns/1ns
`include "saxi_wr_config.svh"

module mult_saxi_wr_arb (
    input  logic                  iclk,
    input  logic                  arst_n,
    chn_rd_if.arb_mp              chn [`SAXI_NCHN],
    output logic                  wr_start,
    output saxi_wr_pkg::wr_addr_t wr_addr,
    output logic [31:0]           wr_data,
    output logic                  wr_valid,
    output logic                  wr_last
);
    import saxi_wr_pkg::*;

    localparam int NCHN        = `SAXI_NCHN;
    localparam int BURST_WORDS = 1 << `SAXI_BSLOG;

    logic [NCHN-1:0]        has_burst_v;
    logic [NCHN-1:0]        pre_valid_v;
    logic [31:0]            data_v [NCHN];
    burst_idx_t             burst_idx [NCHN];  // next address index per channel
    chn_idx_t               cur_chn;           // last channel served
    chn_idx_t               next_chn;
    chn_idx_t               d_chn;             // cur_chn aligned with RAM output
    logic                   found;
    logic [`SAXI_BSLOG:0]   busy_cnt;          // read enable cycles left
    logic                   idle;
    logic                   pv_mux;
    logic [`SAXI_BSLOG-1:0] pv_cnt;            // pre_valid cycles in burst

    for (genvar i = 0; i < NCHN; i++) begin : g_chn
        assign has_burst_v[i]    = chn[i].has_burst;
        assign pre_valid_v[i]    = chn[i].pre_valid;
        assign data_v[i]         = chn[i].data.word;
        assign chn[i].read_burst = wr_start && (next_chn == chn_idx_t'(i));
    end

    // search starts after the channel served last
    always_comb begin
        int unsigned c;
        found    = 1'b0;
        next_chn = cur_chn;
        for (int k = 1; k <= NCHN; k++) begin
            c = (int'(cur_chn) + k) % NCHN;
            if (!found && has_burst_v[c]) begin
                found    = 1'b1;
                next_chn = chn_idx_t'(c);
            end
        end
    end

    assign idle     = (busy_cnt == '0);
    assign wr_start = found & idle;
    assign wr_addr  = {next_chn, burst_idx[next_chn]};  // channel in top bits
    assign pv_mux   = pre_valid_v[cur_chn];
    assign wr_data  = data_v[d_chn];

    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_chn  <= chn_idx_t'(NCHN - 1);  // channel 0 goes first
            d_chn    <= '0;
            busy_cnt <= '0;
            pv_cnt   <= '0;
            wr_valid <= 1'b0;
            wr_last  <= 1'b0;
            for (int i = 0; i < NCHN; i++) begin
                burst_idx[i] <= '0;
            end
        end else begin
            if (wr_start) begin
                cur_chn             <= next_chn;
                busy_cnt            <= BURST_WORDS[`SAXI_BSLOG:0];  // covers t+1..t+16
                burst_idx[next_chn] <= burst_idx[next_chn] + 1'b1;  // wraps
            end else if (!idle) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
            d_chn    <= cur_chn;
            pv_cnt   <= pv_mux ? pv_cnt + 1'b1 : '0;
            wr_valid <= pv_mux;                 // data trails pre_valid by one
            wr_last  <= pv_mux & (&pv_cnt);
        end
    end

endmodule

// ==== hdl/mult_saxi_wr_inbuf.sv ====
// one channel buffer of the write collector
// data_clk side: sample counters, burst pulse to iclk
// iclk side: burst read sequencing, bursts-held count, has_burst
`timescale 1ns/1ns
`include "saxi_wr_config.svh"

module mult_saxi_wr_inbuf (
    input  logic                 iclk,
    input  logic                 arst_n,
    input  logic                 en,
    input  logic                 data_clk,
    input  chn_buf_pkg::sample_t data_in,
    input  logic                 valid,
    chn_rd_if.buf_mp             rd
);
    import chn_buf_pkg::*;

    localparam int SCNT_W = `SAXI_BSLOG + LANE_LOG;  // samples per burst, log2

    logic [1:0]                      dclk_rst_sync;  // arst_n release into data_clk
    logic                            dclk_rst_n;
    logic [1:0]                      en_sync;
    logic                            en_dclk;
    logic [SCNT_W-1:0]               smp_cnt;        // sample within burst
    logic [`SAXI_BUF_BURSTS_LOG-1:0] in_burst;       // burst slot being filled
    logic                            we;
    logic                            wr_last_smp;
    logic                            put_burst;      // @iclk, one burst landed
    logic [1:0]                      buf_re;         // ren, regen
    logic [`SAXI_BSLOG-1:0]          outw_cnt;       // word within burst
    logic [`SAXI_BUF_BURSTS_LOG-1:0] out_burst;      // burst slot being read
    logic                            re_last_word;
    burst_cnt_t                      num_bursts;
    buf_word_t                       rdata;

    always_ff @(posedge data_clk or negedge arst_n) begin
        if (!arst_n) begin
            dclk_rst_sync <= '0;
        end else begin
            dclk_rst_sync <= {dclk_rst_sync[0], 1'b1};
        end
    end
    assign dclk_rst_n = dclk_rst_sync[1];

    always_ff @(posedge data_clk or negedge dclk_rst_n) begin
        if (!dclk_rst_n) begin
            en_sync  <= '0;
            smp_cnt  <= '0;
            in_burst <= '0;
        end else begin
            en_sync <= {en_sync[0], en};
            if (!en_dclk) begin
                smp_cnt  <= '0;  // drop any partial burst
                in_burst <= '0;
            end else if (we) begin
                smp_cnt <= smp_cnt + 1'b1;
                if (wr_last_smp) begin
                    in_burst <= in_burst + 1'b1;
                end
            end
        end
    end

    assign en_dclk     = en_sync[1];
    assign we          = valid & en_dclk;
    assign wr_last_smp = we & (&smp_cnt);  // 32nd sample of a burst

    assign re_last_word = buf_re[0] & (&outw_cnt);

    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            buf_re       <= '0;
            outw_cnt     <= '0;
            out_burst    <= '0;
            num_bursts   <= '0;
            rd.has_burst <= 1'b0;
        end else if (!en) begin
            buf_re       <= '0;
            outw_cnt     <= '0;
            out_burst    <= '0;
            num_bursts   <= '0;
            rd.has_burst <= 1'b0;
        end else begin
            buf_re <= {buf_re[0], rd.read_burst | (buf_re[0] & ~(&outw_cnt))};
            if (buf_re[0]) begin
                outw_cnt <= outw_cnt + 1'b1;
            end
            if (re_last_word) begin
                out_burst <= out_burst + 1'b1;
            end
            if (put_burst && !rd.read_burst) begin
                num_bursts <= num_bursts + 1'b1;
            end else if (!put_burst && rd.read_burst) begin
                num_bursts <= num_bursts - 1'b1;
            end
            // low right after the last held burst is requested
            rd.has_burst <= (|num_bursts[`SAXI_BUF_BURSTS_LOG:1]) |
                            (num_bursts[0] & ~rd.read_burst);
        end
    end

    pulse_cross_clock i_put_burst (
        .src_clk   (data_clk),
        .dst_clk   (iclk),
        .rst_n     (en_dclk),       // disabled channel loses pending pulses
        .in_pulse  (wr_last_smp),
        .out_pulse (put_burst)
    );

    chn_buf_ram i_ram (
        .wclk  (data_clk),
        .waddr ({in_burst, smp_cnt}),
        .we    (we),
        .wdata (data_in),
        .rclk  (iclk),
        .raddr ({out_burst, outw_cnt}),
        .ren   (buf_re[0]),
        .regen (buf_re[1]),
        .rdata (rdata)
    );

    assign rd.pre_valid = buf_re[1];
    assign rd.data      = rdata;

endmodule

// ==== hdl/pulse_cross_clock.sv ====
// single pulse crossing between unrelated clocks
// toggle in source domain, three-stage synchronizer, edge detect
`timescale 1ns/1ns

module pulse_cross_clock (
    input  logic src_clk,
    input  logic dst_clk,
    input  logic rst_n,
    input  logic in_pulse,
    output logic out_pulse
);

    logic       tgl;       // flips once per source pulse
    logic [2:0] tgl_sync;  // dst_clk copies of tgl

    always_ff @(posedge src_clk or negedge rst_n) begin
        if (!rst_n) begin
            tgl <= 1'b0;
        end else if (in_pulse) begin
            tgl <= ~tgl;
        end
    end

    // stage 0 may go metastable, stages 1 and 2 are compared
    always_ff @(posedge dst_clk or negedge rst_n) begin
        if (!rst_n) begin
            tgl_sync <= '0;
        end else begin
            tgl_sync <= {tgl_sync[1:0], tgl};
        end
    end

    assign out_pulse = tgl_sync[2] ^ tgl_sync[1];  // one dst cycle per toggle

endmodule

// ==== hdl/saxi_wr_config.svh ====
// build-time sizes for the multi-channel write collector
// sample width, burst length, channel count, buffer depth, address index
`ifndef SAXI_WR_CONFIG_SVH
`define SAXI_WR_CONFIG_SVH

// input sample width, log2 (4 -> 16 bits)
`define SAXI_WLOG 4

// burst length in 32-bit words, log2 (4 -> 16 words)
`define SAXI_BSLOG 4

`define SAXI_NCHN 2                // number of input channels

// bursts held per channel buffer, log2
`define SAXI_BUF_BURSTS_LOG 3

// per-channel burst index bits in the output address
`define SAXI_ADDR_BURST_LOG 4

`endif

// ==== hdl/saxi_wr_pkg.sv ====
// output stream types
// channel index, per-channel burst index and burst address
`include "saxi_wr_config.svh"

package saxi_wr_pkg;

    // at least one bit even for a single channel
    localparam int CHN_W = (`SAXI_NCHN > 1) ? $clog2(`SAXI_NCHN) : 1;

    // channel number on top of the burst index
    localparam int ADDR_W = CHN_W + `SAXI_ADDR_BURST_LOG;

    typedef logic [CHN_W-1:0] chn_idx_t;

    typedef logic [`SAXI_ADDR_BURST_LOG-1:0] burst_idx_t;  // wraps per channel

    typedef logic [ADDR_W-1:0] wr_addr_t;

endpackage

// ==== sim.f ====
+incdir+hdl
hdl/chn_buf_pkg.sv
hdl/saxi_wr_pkg.sv
hdl/chn_rd_if.sv
hdl/pulse_cross_clock.sv
hdl/chn_buf_ram.sv
hdl/mult_saxi_wr_inbuf.sv
hdl/mult_saxi_wr_arb.sv
hdl/mult_saxi_wr.sv
verif/mult_saxi_wr_properties.sv
verif/tb_mult_saxi_wr.sv

// ==== verif/mult_saxi_wr_properties.sv ====
// concurrent checks on the arbiter
// one read_burst at a time, only with has_burst, 16-word valid runs, wr_last placement
`timescale 1ns/1ns
`include "saxi_wr_config.svh"

module mult_saxi_wr_properties (
    input logic                  iclk,
    input logic                  arst_n,
    input logic [`SAXI_NCHN-1:0] has_burst_v,
    input logic [`SAXI_NCHN-1:0] read_burst_v,
    input logic                  wr_start,
    input logic                  wr_valid,
    input logic                  wr_last
);

    localparam int BLEN = 1 << `SAXI_BSLOG;

    logic [`SAXI_BSLOG:0] run;  // wr_valid cycles so far in this run

    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            run <= '0;
        end else begin
            run <= wr_valid ? run + 1'b1 : '0;
        end
    end

    a_one_read: assert property (@(posedge iclk) disable iff (!arst_n)
        $onehot0(read_burst_v))
        else $error("read_burst high on more than one channel");

    a_read_has: assert property (@(posedge iclk) disable iff (!arst_n)
        (read_burst_v & ~has_burst_v) == '0)
        else $error("read_burst without has_burst");

    a_start_valid: assert property (@(posedge iclk) disable iff (!arst_n)
        wr_start |-> ##3 wr_valid)
        else $error("wr_valid not high three cycles after wr_start");

    a_run_max: assert property (@(posedge iclk) disable iff (!arst_n)
        wr_valid |-> (run < BLEN))
        else $error("wr_valid run longer than one burst");

    a_run_len: assert property (@(posedge iclk) disable iff (!arst_n)
        (!wr_valid && run != '0) |-> (run == BLEN))
        else $error("wr_valid run ended early");

    a_last: assert property (@(posedge iclk) disable iff (!arst_n)
        wr_last == (wr_valid && run == BLEN - 1))
        else $error("wr_last not on the last word of the burst");

endmodule

// ==== verif/saxi_wr_tests.txt ====
# name drop en_mask(hex) ch0_samples ch1_samples bursts first_addr(hex) order(hex)
# drop 1 pulls all enables low first; order bit k is the channel of burst k
thresh31   0 1   31    0  0 00 0000
thresh32   0 1    1    0  1 00 0000
robin      0 3  128  128  8 10 0055
wrap_ch1   0 3    0  416 13 14 1fff
partial    0 1   10    0  0 00 0000
disable    1 1   32    0  1 05 0000
mixed      0 3   64   32  3 11 0001
wrap_ch0   0 1  352    0 11 08 0000
split_a    0 3   48   16  1 03 0000
split_b    0 3   16   48  3 12 0005

// ==== verif/tb_mult_saxi_wr.sv ====
// testbench for the multi-channel write collector
// reads tests from a data file, drives LFSR samples per channel,
// checks packing, burst count, addresses and channel order on the stream
`timescale 1ns/1ns
`include "saxi_wr_config.svh"

module tb_mult_saxi_wr;
    import saxi_wr_pkg::*;

    localparam int NCHN  = `SAXI_NCHN;
    localparam int SMP_W = 1 << `SAXI_WLOG;
    localparam int BLEN  = 1 << `SAXI_BSLOG;  // words per burst
    localparam int IDX_W = `SAXI_ADDR_BURST_LOG;
    localparam int WAIT_MAX = 4000;           // iclk cycles per drain wait

    logic                  iclk;
    logic                  data_clk;
    logic                  arst_n;
    logic [NCHN-1:0]       en;
    logic [NCHN*SMP_W-1:0] data_in;
    logic [NCHN-1:0]       valid;
    logic                  wr_start;
    wr_addr_t              wr_addr;
    logic [31:0]           wr_data;
    logic                  wr_valid;
    logic                  wr_last;

    logic [15:0]      lfsr [NCHN];       // sample source per channel
    logic [31:0]      exp_q [NCHN][$];   // expected words, oldest first
    logic [SMP_W-1:0] half [NCHN];       // earlier sample of an unfinished word
    logic             half_ok [NCHN];
    int               idx_m [NCHN];      // next burst index per channel
    int               pend_q [$];        // channels of bursts still streaming
    int               word_cnt;
    int               n_bursts;          // bursts started in this test
    logic [31:0]      order_v;           // bit k set when burst k came from channel 1
    wr_addr_t         first_addr;
    int               err_cnt;
    int               n_tests;
    int               n_bad;
    string            cur_name;

    mult_saxi_wr i_mult_saxi_wr (
        .iclk     (iclk),
        .arst_n   (arst_n),
        .data_clk (data_clk),
        .en       (en),
        .data_in  (data_in),
        .valid    (valid),
        .wr_start (wr_start),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_valid (wr_valid),
        .wr_last  (wr_last)
    );

    bind mult_saxi_wr_arb mult_saxi_wr_properties i_props (
        .iclk         (iclk),
        .arst_n       (arst_n),
        .has_burst_v  (has_burst_v),
        .read_burst_v ({chn[1].read_burst, chn[0].read_burst}),
        .wr_start     (wr_start),
        .wr_valid     (wr_valid),
        .wr_last      (wr_last)
    );

    initial begin
        iclk = 1'b0;
        forever #4 iclk = ~iclk;  // 8 ns
    end

    initial begin
        data_clk = 1'b0;
        forever #5 data_clk = ~data_clk;  // 10 ns
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic next_sample(input int c, output logic [SMP_W-1:0] smp);
        for (int b = 0; b < SMP_W; b++) begin
            smp[b]  = lfsr[c][0];  // one step per bit
            lfsr[c] = lfsr_next(lfsr[c]);
        end
    endtask

    // first sample of a pair goes to the low half
    task automatic push_sample(input int c, input logic [SMP_W-1:0] smp);
        if (half_ok[c]) begin
            exp_q[c].push_back({smp, half[c]});
            half_ok[c] = 1'b0;
        end else begin
            half[c]    = smp;
            half_ok[c] = 1'b1;
        end
    endtask

    task automatic clear_model(input int c);
        exp_q[c].delete();
        half_ok[c] = 1'b0;
    endtask

    task automatic send_samples(input int n0, input int n1);
        int               n [2];
        int               top;
        logic [SMP_W-1:0] smp;
        n[0] = n0;
        n[1] = n1;
        top  = (n0 > n1) ? n0 : n1;
        for (int i = 0; i < top; i++) begin
            @(posedge data_clk);
            #1;
            for (int c = 0; c < NCHN; c++) begin
                valid[c] = (i < n[c]);
                if (i < n[c]) begin
                    next_sample(c, smp);
                    data_in[c*SMP_W +: SMP_W] = smp;
                    push_sample(c, smp);
                end
            end
        end
        @(posedge data_clk);
        #1;
        valid = '0;
    endtask

    task automatic run_test(input string name, input int drop, input logic [NCHN-1:0] mask,
                            input int n0, input int n1, input int exp_bursts,
                            input logic [31:0] exp_first, input logic [31:0] exp_order);
        int err_start;
        int t;
        cur_name  = name;
        err_start = err_cnt;
        if (drop != 0) begin
            @(posedge iclk);
            #1;
            en = '0;                      // held samples are lost
            repeat (8) @(posedge data_clk);
        end
        @(posedge iclk);
        #1;
        en = mask;
        for (int c = 0; c < NCHN; c++) begin
            if (drop != 0 || !mask[c]) begin
                clear_model(c);
            end
        end
        repeat (6) @(posedge data_clk);   // enable reaches data_clk side
        n_bursts = 0;
        order_v  = '0;
        send_samples(n0, n1);
        t = 0;
        while ((n_bursts < exp_bursts || pend_q.size() != 0) && t < WAIT_MAX) begin
            @(posedge iclk);
            t++;
        end
        if (t >= WAIT_MAX) begin
            $display("test %s timed out waiting for bursts to finish", name);
            err_cnt++;
        end
        repeat (200) @(posedge iclk);     // room for an unwanted burst
        if (n_bursts != exp_bursts) begin
            $display("FAIL %s bursts expected %0d actual %0d", name, exp_bursts, n_bursts);
            err_cnt++;
        end
        if (exp_bursts > 0 && first_addr != exp_first[ADDR_W-1:0]) begin
            $display("FAIL %s first address expected %h actual %h", name,
                     exp_first[ADDR_W-1:0], first_addr);
            err_cnt++;
        end
        if (order_v != exp_order) begin
            $display("FAIL %s channel order expected %h actual %h", name, exp_order, order_v);
            err_cnt++;
        end
        n_tests++;
        if (err_cnt == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - err_start);
            n_bad++;
        end
    endtask

    // stream monitor, outputs are settled at the falling edge
    always @(negedge iclk) begin
        int          ch;
        int          idx;
        logic [31:0] exp_w;
        if (arst_n) begin
            if (wr_start) begin
                ch  = int'(wr_addr[ADDR_W-1:IDX_W]);  // channel in top bits
                idx = int'(wr_addr[IDX_W-1:0]);
                if (n_bursts == 0) begin
                    first_addr = wr_addr;
                end
                if (!en[ch]) begin
                    $display("test %s: wr_start for a channel that is not enabled", cur_name);
                    err_cnt++;
                end
                if (idx != idx_m[ch]) begin
                    $display("FAIL %s burst index expected %0d actual %0d",
                             cur_name, idx_m[ch], idx);
                    err_cnt++;
                end
                idx_m[ch] = (idx_m[ch] + 1) % (1 << IDX_W);
                pend_q.push_back(ch);
                if (n_bursts < 32) begin
                    order_v[n_bursts] = (ch != 0);
                end
                n_bursts++;
            end
            if (wr_valid) begin
                if (pend_q.size() == 0) begin
                    $display("test %s: wr_valid seen with no burst started", cur_name);
                    err_cnt++;
                end else begin
                    ch = pend_q[0];
                    if (exp_q[ch].size() == 0) begin
                        $display("test %s: data word with no sample sent to it", cur_name);
                        err_cnt++;
                    end else begin
                        exp_w = exp_q[ch].pop_front();
                        if (wr_data !== exp_w) begin
                            $display("FAIL %s data expected %h actual %h",
                                     cur_name, exp_w, wr_data);
                            err_cnt++;
                        end
                    end
                    word_cnt++;
                    if (wr_last !== (word_cnt == BLEN)) begin
                        $display("FAIL %s wr_last at word %0d expected %b actual %b",
                                 cur_name, word_cnt, (word_cnt == BLEN), wr_last);
                        err_cnt++;
                    end
                    if (word_cnt == BLEN) begin
                        void'(pend_q.pop_front());
                        word_cnt = 0;
                    end
                end
            end else if (wr_last) begin
                $display("test %s: wr_last seen without wr_valid", cur_name);
                err_cnt++;
            end
        end
    end

    initial begin
        int              fd;
        int              n_fields;
        string           line;
        string           name;
        int              drop;
        int              n0;
        int              n1;
        int              exp_bursts;
        logic [NCHN-1:0] mask;
        logic [31:0]     exp_first;
        logic [31:0]     exp_order;
        arst_n     = 1'b0;
        en         = '0;
        data_in    = '0;
        valid      = '0;
        err_cnt    = 0;
        n_tests    = 0;
        n_bad      = 0;
        n_bursts   = 0;
        word_cnt   = 0;
        order_v    = '0;
        first_addr = '0;
        cur_name   = "reset";
        for (int c = 0; c < NCHN; c++) begin
            lfsr[c] = 16'd62;
            repeat (8 * c) lfsr[c] = lfsr_next(lfsr[c]);  // channel streams start apart
            half_ok[c] = 1'b0;
            idx_m[c]   = 0;
        end
        repeat (10) @(posedge iclk);
        #1;
        arst_n = 1'b1;
        fd = $fopen("verif/saxi_wr_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n_fields = $sscanf(line, "%s %d %h %d %d %d %h %h", name, drop, mask,
                                       n0, n1, exp_bursts, exp_first, exp_order);
                    if (n_fields == 8) begin
                        run_test(name, drop, mask, n0, n1, exp_bursts, exp_first, exp_order);
                    end else begin
                        $display("malformed line in test data file: %s", line);
                        err_cnt++;
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests run %0d, failing tests %0d, failed checks %0d",
                 n_tests, n_bad, err_cnt);
        if (err_cnt == 0 && n_tests > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #500000;
        $display("simulation time limit reached before all tests finished");
        $display("Test failed");
        $finish;
    end

endmodule
